// File: controlStore.sv
`timescale 1ns/10ps

module controlStore import kl10Pkg::*; #(
    parameter int CRAM_DEPTH = 2048
) (
    input  logic                  eboxClk,
    input  logic                  arstN,
    input  tCRADR                 nextAdr,
    input  logic                  loadCram,
    input  tCRADR                 loadAdr,
    input  logic [CRAM_WIDTH-1:0] loadData,
    output tuCRAM                 cramWord
);

    // Address bits that actually reach the array
    localparam int ADR_BITS = $clog2(CRAM_DEPTH);

    // Microcode array, no reset
    logic [CRAM_WIDTH-1:0] mem [CRAM_DEPTH];

    logic readInRange;
    logic loadInRange;

    // Addresses past the array read as zero and ignore writes
    assign readInRange = int'(nextAdr) < CRAM_DEPTH;
    assign loadInRange = int'(loadAdr) < CRAM_DEPTH;

    // Load port
    always_ff @(posedge eboxClk) begin
        if (loadCram && loadInRange) begin
            mem[loadAdr[ADR_BITS-1:0]] <= loadData;
        end
    end

    // Registered read
    // one cycle from nextAdr to cramWord
    always_ff @(posedge eboxClk or negedge arstN) begin
        if (!arstN) begin
            cramWord.all <= '0;
        end else if (readInRange) begin
            cramWord.all <= mem[nextAdr[ADR_BITS-1:0]];
        end else begin
            cramWord.all <= '0;
        end
    end

endmodule

// File: dispatchStore.sv
`timescale 1ns/10ps

module dispatchStore import kl10Pkg::*; (
    input  logic                  eboxClk,
    input  logic                  arstN,
    input  tIrOp                  irOp,
    input  logic                  loadDram,
    input  tCRADR                 loadAdr,
    input  logic [CRAM_WIDTH-1:0] loadData,
    output tDRAM                  drWord
);

    // One dispatch word per opcode
    tDRAM dram [DRAM_DEPTH];

    tIrOp loadOp;
    tDRAM loadWord;

    // Low bits of the shared load bus
    assign loadOp   = loadAdr[IROP_WIDTH-1:0];
    assign loadWord = loadData[$bits(tDRAM)-1:0];

    always_ff @(posedge eboxClk) begin
        if (loadDram) begin
            dram[loadOp] <= loadWord;
        end
    end

    // Follows irOp with one cycle of latency
    always_ff @(posedge eboxClk or negedge arstN) begin
        if (!arstN) begin
            drWord <= '0;
        end else begin
            drWord <= dram[irOp];
        end
    end

endmodule

// File: kl10Pkg.sv
package kl10Pkg;

    // Word and address sizes
    localparam int CRAM_WIDTH  = 84;
    localparam int CRADR_WIDTH = 11;
    localparam int IROP_WIDTH  = 9;

    // DRAM has one entry per opcode
    localparam int DRAM_DEPTH = 512;

    // External skip condition inputs
    localparam int NUM_CONDS = 8;

    // Control RAM address, bit 0 is the low (skip) bit
    typedef logic [CRADR_WIDTH-1:0] tCRADR;

    // Instruction opcode, indexes the DRAM
    typedef logic [IROP_WIDTH-1:0] tIrOp;

    typedef logic [5:0] tCondCode;
    typedef logic [4:0] tDispCode;

    // DISP field codes, anything else behaves as none
    localparam tDispCode DISP_NONE   = 5'd0;
    localparam tDispCode DISP_DRAM   = 5'd1;
    localparam tDispCode DISP_RETURN = 5'd2;

    // COND field, 1..8 select conds[code-1]
    localparam tCondCode COND_NONE = 6'd0;
    localparam tCondCode COND_LAST = 6'd8;

    // Field view of a control word, bit 0 is the leftmost
    typedef struct packed {
        logic       unused0;
        tCRADR      J;
        // Data path fields, carried through untouched
        logic [5:0] AD;
        logic [2:0] ADA;
        logic       unused21;
        logic [1:0] ADB;
        logic [2:0] AR;
        logic [2:0] ARX;
        logic       BR;
        logic       BRX;
        logic       MQ;
        logic [2:0] FMADR;
        logic [2:0] SCAD;
        logic [2:0] SCADA;
        logic       unused42;
        logic [1:0] SCADB;
        logic       unused45;
        logic       SC;
        logic       FE;
        logic       unused48;
        logic [1:0] SH;
        logic       unused51;
        logic [1:0] VMA;
        logic [1:0] TIME;
        logic [3:0] MEM;
        // Sequencing fields
        tCondCode   COND;
        logic       CALL;
        tDispCode   DISP;
        logic [1:0] spare;
        logic       MARK;
        logic [8:0] MAGIC;
    } tCramFields;

    // Stores see raw bits, the sequencer sees fields
    typedef union packed {
        logic [0:CRAM_WIDTH-1] all;
        tCramFields            fields;
    } tuCRAM;

    // Dispatch RAM word, J in the low 11 bits
    typedef struct packed {
        logic [2:0] A;
        logic [2:0] B;
        logic       parity;
        logic [5:0] spare;
        tCRADR      J;
    } tDRAM;

endpackage

// File: microControl.sv
`timescale 1ns/10ps

module microControl import kl10Pkg::*; #(
    parameter int CRAM_DEPTH  = 2048,
    parameter int STACK_DEPTH = 4
) (
    input  logic                  eboxClk,
    input  logic                  arstN,
    input  logic                  run,
    input  tIrOp                  irOp,
    input  logic [NUM_CONDS-1:0]  conds,
    input  logic                  loadCram,
    input  logic                  loadDram,
    input  tCRADR                 loadAdr,
    input  logic [CRAM_WIDTH-1:0] loadData,
    output tuCRAM                 cramWord,
    output tCRADR                 cradr
);

    // Sequencer to CRAM address
    tCRADR nextAdr;

    // DRAM word for the current opcode
    tDRAM drWord;

    // CRAM, the word in execution
    controlStore #(
        .CRAM_DEPTH(CRAM_DEPTH)
    ) cram (
        .eboxClk (eboxClk),
        .arstN   (arstN),
        .nextAdr (nextAdr),
        .loadCram(loadCram),
        .loadAdr (loadAdr),
        .loadData(loadData),
        .cramWord(cramWord)
    );

    // DRAM, indexed by opcode
    dispatchStore dram (
        .eboxClk (eboxClk),
        .arstN   (arstN),
        .irOp    (irOp),
        .loadDram(loadDram),
        .loadAdr (loadAdr),
        .loadData(loadData),
        .drWord  (drWord)
    );

    // Next address and return stack
    microSequencer #(
        .STACK_DEPTH(STACK_DEPTH)
    ) seq (
        .eboxClk (eboxClk),
        .arstN   (arstN),
        .run     (run),
        .cramWord(cramWord),
        .drWord  (drWord),
        .conds   (conds),
        .nextAdr (nextAdr),
        .cradr   (cradr)
    );

endmodule

// File: microControlTb.sv
`timescale 1ns/10ps

module microControlTb import kl10Pkg::*; ();

    localparam int CRAM_DEPTH    = 2048;
    localparam int STACK_DEPTH   = 4;
    localparam int CLK_PERIOD_NS = 100;
    localparam int RESET_CYCLES  = 3;
    localparam int SEED          = 83247;

    // Test lengths in cycles
    localparam int SETTLE        = 4;
    localparam int CHAIN_LEN     = 16;
    localparam int CHAIN_RUN     = 40;
    localparam int SKIP_PAIRS    = 8;
    localparam int SKIP_RUN      = 120;
    localparam int DISP_OPS      = 6;
    localparam int DISP_RUN      = 12;
    localparam int CALL_DEPTH    = STACK_DEPTH + 2;
    localparam int CALL_BASE     = 256;
    localparam int CALL_RUN      = 48;
    localparam int RAND_PASSES   = 4;
    localparam int RAND_RUN      = 500;
    localparam int PROG_OVERHEAD = 1 + 2 * SETTLE;
    localparam int TOTAL_CYCLES  = RESET_CYCLES + SETTLE
        + CHAIN_LEN + PROG_OVERHEAD + CHAIN_RUN
        + 2 * SKIP_PAIRS + PROG_OVERHEAD + SKIP_RUN
        + DISP_OPS * (3 + PROG_OVERHEAD + DISP_RUN)
        + 2 * CALL_DEPTH + 4 + PROG_OVERHEAD + CALL_RUN
        + CRAM_DEPTH + DRAM_DEPTH + RAND_PASSES * (PROG_OVERHEAD + RAND_RUN) + 2;
    localparam int TIMEOUT_NS    = (TOTAL_CYCLES + 50) * CLK_PERIOD_NS;

    logic                  eboxClk;
    logic                  arstN;
    logic                  run;
    tIrOp                  irOp;
    logic [NUM_CONDS-1:0]  conds;
    logic                  loadCram;
    logic                  loadDram;
    tCRADR                 loadAdr;
    logic [CRAM_WIDTH-1:0] loadData;
    tuCRAM                 cramWord;
    tCRADR                 cradr;

    // Model copies of both stores, as the DUT holds them
    tuCRAM cramImg   [CRAM_DEPTH];
    bit    cramKnown [CRAM_DEPTH];
    tDRAM  dramImg   [DRAM_DEPTH];

    // Model state, what the outputs should show after the last edge
    tCRADR expAdr;
    tuCRAM expWord;
    logic  expKnown;
    tDRAM  expDr;
    tCRADR modelStack [$];

    int checks     = 0;
    int adrErrors  = 0;
    int wordErrors = 0;

    tbClock #(
        .PERIOD_NS   (CLK_PERIOD_NS),
        .RESET_CYCLES(RESET_CYCLES)
    ) clockGen (
        .eboxClk(eboxClk),
        .arstN  (arstN)
    );

    microControl #(
        .CRAM_DEPTH (CRAM_DEPTH),
        .STACK_DEPTH(STACK_DEPTH)
    ) i_dut (
        .eboxClk (eboxClk),
        .arstN   (arstN),
        .run     (run),
        .irOp    (irOp),
        .conds   (conds),
        .loadCram(loadCram),
        .loadDram(loadDram),
        .loadAdr (loadAdr),
        .loadData(loadData),
        .cramWord(cramWord),
        .cradr   (cradr)
    );

    // Expected next address, straight from the sequencing rules
    function automatic tCRADR refNextAdr(logic runNow, tuCRAM word, tDRAM dr,
                                         logic [NUM_CONDS-1:0] cv, tCRADR popTop);
        tCRADR adr;
        int    code;
        if (!runNow) begin
            return '0;
        end
        adr = word.fields.J;
        if (word.fields.DISP == DISP_DRAM) begin
            adr |= dr.J;
        end else if (word.fields.DISP == DISP_RETURN) begin
            adr |= popTop;
        end
        // Codes 1..8 pick conds[code-1]
        code = int'(word.fields.COND);
        if (code >= 1 && code <= NUM_CONDS && cv[3'(code - 1)]) begin
            adr[0] = 1'b1;
        end
        return adr;
    endfunction

    task automatic checkAdr(string name, tCRADR expected, tCRADR actual);
        checks++;
        if (actual !== expected) begin
            adrErrors++;
            $display("FAILED %s expected %h actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic checkWord(string name, tuCRAM expected, tuCRAM actual);
        checks++;
        if (actual !== expected) begin
            wordErrors++;
            $display("FAILED %s expected %h actual %h at %0t",
                     name, expected.all, actual.all, $time);
        end
    endtask

    // Compare, then step the model, on the falling edge
    always @(negedge eboxClk) begin : compareModel
        tCRADR top;
        tCRADR nxt;
        if (!arstN) begin
            expAdr      = '0;
            expWord.all = '0;
            expKnown    = 1'b1;
            expDr       = '0;
            modelStack.delete();
        end else begin
            checkAdr("cradr", expAdr, cradr);
            // Words never loaded are not compared
            if (expKnown) begin
                checkWord("cramWord", expWord, cramWord);
            end
            top = (modelStack.size() > 0) ? modelStack[0] : '0;
            nxt = refNextAdr(run, expWord, expDr, conds, top);
            if (!run) begin
                modelStack.delete();
            end else begin
                // Pop before push
                if (expWord.fields.DISP == DISP_RETURN && modelStack.size() > 0) begin
                    void'(modelStack.pop_front());
                end
                if (expWord.fields.CALL) begin
                    modelStack.push_front(expAdr);
                    if (modelStack.size() > STACK_DEPTH) begin
                        void'(modelStack.pop_back());
                    end
                end
            end
            expAdr   = nxt;
            expWord  = cramImg[nxt];
            expKnown = cramKnown[nxt];
            expDr    = dramImg[irOp];
            // Writes land after the read on the same edge
            if (loadCram) begin
                cramImg[loadAdr].all = loadData;
                cramKnown[loadAdr]   = 1'b1;
            end
            if (loadDram) begin
                dramImg[loadAdr[IROP_WIDTH-1:0]] = tDRAM'(loadData[$bits(tDRAM)-1:0]);
            end
        end
    end

    // New random conditions every cycle
    initial begin
        conds = '0;
        forever begin
            @(posedge eboxClk);
            conds <= 8'($urandom);
        end
    end

    // Random data fields, no skip, call or dispatch
    function automatic tuCRAM plainWord(tCRADR j);
        tuCRAM w;
        w.all         = CRAM_WIDTH'({$urandom(), $urandom(), $urandom()});
        w.fields.J    = j;
        w.fields.COND = COND_NONE;
        w.fields.CALL = 1'b0;
        w.fields.DISP = DISP_NONE;
        return w;
    endfunction

    task automatic loadCramWord(tCRADR adr, tuCRAM w);
        @(posedge eboxClk);
        loadCram <= 1'b1;
        loadDram <= 1'b0;
        loadAdr  <= adr;
        loadData <= w.all;
    endtask

    // Upper load bits are junk the DRAM must ignore
    task automatic loadDramWord(tIrOp op, tDRAM dr);
        logic [CRAM_WIDTH-1:0] data;
        data                     = CRAM_WIDTH'({$urandom(), $urandom(), $urandom()});
        data[$bits(tDRAM)-1:0]   = dr;
        @(posedge eboxClk);
        loadCram <= 1'b0;
        loadDram <= 1'b1;
        loadAdr  <= tCRADR'(op);
        loadData <= data;
    endtask

    task automatic holdIdle(int n);
        @(posedge eboxClk);
        run      <= 1'b0;
        loadCram <= 1'b0;
        loadDram <= 1'b0;
        repeat (n - 1) @(posedge eboxClk);
    endtask

    // Opcode change with run low, DRAM read settles before run
    task automatic runProgram(tIrOp op, int n);
        @(posedge eboxClk);
        loadCram <= 1'b0;
        loadDram <= 1'b0;
        irOp     <= op;
        holdIdle(SETTLE);
        @(posedge eboxClk);
        run <= 1'b1;
        repeat (n - 1) @(posedge eboxClk);
        holdIdle(SETTLE);
    endtask

    // Closed ring of plain words starting at 0
    task automatic testChain();
        tCRADR ring [CHAIN_LEN];
        ring[0] = '0;
        for (int i = 1; i < CHAIN_LEN; i++) begin
            ring[i] = tCRADR'($urandom);
        end
        for (int i = 0; i < CHAIN_LEN; i++) begin
            loadCramWord(ring[i], plainWord(ring[(i + 1) % CHAIN_LEN]));
        end
        runProgram('0, CHAIN_RUN);
    endtask

    // Even/odd pairs, either one goes on to the next pair
    task automatic testSkip();
        tuCRAM w;
        for (int a = 0; a < 2 * SKIP_PAIRS; a++) begin
            w = plainWord(tCRADR'(2 * (((a / 2) + 1) % SKIP_PAIRS)));
            if ($urandom_range(0, 1) == 1) begin
                w.fields.COND = 6'($urandom_range(1, NUM_CONDS));
            end else begin
                w.fields.COND = 6'($urandom_range(0, 63));
            end
            loadCramWord(tCRADR'(a), w);
        end
        runProgram('0, SKIP_RUN);
    endtask

    task automatic testDispatch();
        tIrOp  op;
        tDRAM  dr;
        tCRADR base;
        tuCRAM w;
        for (int k = 0; k < DISP_OPS; k++) begin
            op            = tIrOp'($urandom);
            dr            = 24'($urandom);
            base          = tCRADR'($urandom);
            w             = plainWord(base);
            w.fields.DISP = DISP_DRAM;
            loadDramWord(op, dr);
            loadCramWord('0, w);
            // Target word loops back to 0
            loadCramWord(base | dr.J, plainWord('0));
            runProgram(op, DISP_RUN);
        end
    endtask

    // Nest past the stack depth, unwind with J=1
    task automatic testCallReturn();
        tuCRAM w;
        tCRADR here;
        loadCramWord('0, plainWord(tCRADR'(CALL_BASE)));
        // Reached by the pop of an empty stack
        loadCramWord(tCRADR'(1), plainWord('0));
        for (int i = 0; i <= CALL_DEPTH; i++) begin
            here = tCRADR'(CALL_BASE + 16 * i);
            if (i < CALL_DEPTH) begin
                w             = plainWord(tCRADR'(CALL_BASE + 16 * (i + 1)));
                w.fields.CALL = 1'b1;
            end else begin
                w             = plainWord(tCRADR'(1));
                w.fields.DISP = DISP_RETURN;
            end
            loadCramWord(here, w);
            w             = plainWord(tCRADR'(1));
            w.fields.DISP = DISP_RETURN;
            loadCramWord(here | tCRADR'(1), w);
        end
        runProgram('0, CALL_RUN);
    endtask

    // Fully random stores, new opcode each pass
    task automatic testRandom();
        tuCRAM w;
        for (int a = 0; a < CRAM_DEPTH; a++) begin
            w.all = CRAM_WIDTH'({$urandom(), $urandom(), $urandom()});
            loadCramWord(tCRADR'(a), w);
        end
        for (int a = 0; a < DRAM_DEPTH; a++) begin
            loadDramWord(tIrOp'(a), 24'($urandom));
        end
        for (int p = 0; p < RAND_PASSES; p++) begin
            runProgram(tIrOp'($urandom), RAND_RUN);
        end
    endtask

    initial begin : stimulus
        void'($urandom(SEED));
        run      = 1'b0;
        irOp     = '0;
        loadCram = 1'b0;
        loadDram = 1'b0;
        loadAdr  = '0;
        loadData = '0;
        wait (arstN);
        holdIdle(SETTLE);
        testChain();
        testSkip();
        testDispatch();
        testCallReturn();
        testRandom();
        // Let the last compare finish
        repeat (2) @(posedge eboxClk);
        $display("Checks %0d, cradr errors %0d, cramWord errors %0d",
                 checks, adrErrors, wordErrors);
        if (adrErrors + wordErrors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout, the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: microSequencer.sv
`timescale 1ns/10ps

module microSequencer import kl10Pkg::*; #(
    parameter int STACK_DEPTH = 4
) (
    input  logic                 eboxClk,
    input  logic                 arstN,
    input  logic                 run,
    input  tuCRAM                cramWord,
    input  tDRAM                 drWord,
    input  logic [NUM_CONDS-1:0] conds,
    output tCRADR                nextAdr,
    output tCRADR                cradr
);

    localparam int CNT_BITS  = $clog2(STACK_DEPTH + 1);
    localparam int COND_BITS = $clog2(NUM_CONDS);

    // Return stack, entry 0 is the top
    tCRADR               stack     [STACK_DEPTH];
    tCRADR               stackNext [STACK_DEPTH];
    logic [CNT_BITS-1:0] stackCnt;
    logic [CNT_BITS-1:0] stackCntNext;

    tCondCode condCode;
    tCondCode condIdx;
    logic     skip;
    logic     doCall;
    logic     doReturn;
    tCRADR    popAdr;
    tCRADR    dispAdr;

    // Skip select
    assign condCode = cramWord.fields.COND;
    assign condIdx  = condCode - 6'd1;
    // Codes above COND_LAST never skip
    assign skip = (condCode != COND_NONE) && (condCode <= COND_LAST) &&
                  conds[condIdx[COND_BITS-1:0]];

    // Stack ops only while running
    assign doCall   = run && cramWord.fields.CALL;
    assign doReturn = run && (cramWord.fields.DISP == DISP_RETURN);

    // Empty stack pops as zero
    assign popAdr = (stackCnt != '0) ? stack[0] : '0;

    // Address bits ORed in by the dispatch kind
    always_comb begin
        case (cramWord.fields.DISP)
            DISP_NONE:   dispAdr = '0;
            DISP_DRAM:   dispAdr = drWord.J;
            DISP_RETURN: dispAdr = popAdr;
            default:     dispAdr = '0;
        endcase
    end

    // Next address, J plus dispatch plus skip
    always_comb begin
        if (!run) begin
            nextAdr = '0;
        end else begin
            nextAdr    = cramWord.fields.J | dispAdr;
            nextAdr[0] = nextAdr[0] | skip;
        end
    end

    // Stack next state
    // pop first, then push
    always_comb begin
        stackNext    = stack;
        stackCntNext = stackCnt;
        if (doReturn && (stackCnt != '0)) begin
            for (int i = 0; i < STACK_DEPTH - 1; i++) begin
                stackNext[i] = stack[i + 1];
            end
            stackNext[STACK_DEPTH-1] = '0;
            stackCntNext             = stackCnt - 1'b1;
        end
        if (doCall) begin
            // Bottom entry falls off when full
            for (int i = STACK_DEPTH - 1; i > 0; i--) begin
                stackNext[i] = stackNext[i - 1];
            end
            stackNext[0] = cradr;
            if (stackCntNext != CNT_BITS'(STACK_DEPTH)) begin
                stackCntNext = stackCntNext + 1'b1;
            end
        end
    end

    // Stack entries, meaningful only below stackCnt
    always_ff @(posedge eboxClk) begin
        for (int i = 0; i < STACK_DEPTH; i++) begin
            stack[i] <= stackNext[i];
        end
    end

    // Entry count, emptied while halted
    always_ff @(posedge eboxClk or negedge arstN) begin
        if (!arstN) begin
            stackCnt <= '0;
        end else if (!run) begin
            stackCnt <= '0;
        end else begin
            stackCnt <= stackCntNext;
        end
    end

    // Same edge as the CRAM read, so cradr tracks cramWord
    always_ff @(posedge eboxClk or negedge arstN) begin
        if (!arstN) begin
            cradr <= '0;
        end else begin
            cradr <= nextAdr;
        end
    end

endmodule

// File: runSim.sh
#!/usr/bin/env bash
# Build and run the microcode control testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f sim.f --top-module microControlTb -o simv
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
    echo "Verilator build failed with status $buildStatus"
    exit 1
fi

simOutput=$(./obj_dir/simv)
simStatus=$?
echo "$simOutput"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

# Pass only when the testbench printed its pass line
if echo "$simOutput" | grep -qx "Simulation PASSED"; then
    exit 0
fi
echo "Pass line not found in the simulation output"
exit 1

// File: sim.f
kl10Pkg.sv
controlStore.sv
dispatchStore.sv
microSequencer.sv
microControl.sv
tbClock.sv
microControlTb.sv

// File: tbClock.sv
`timescale 1ns/10ps

module tbClock #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 3
) (
    output logic eboxClk,
    output logic arstN
);

    // Free running EBOX clock
    initial begin
        eboxClk = 1'b0;
        forever #(PERIOD_NS / 2) eboxClk = ~eboxClk;
    end

    // Reset held over the first rising edges
    // then released on an edge, after the flops have sampled it
    initial begin
        arstN = 1'b0;
        repeat (RESET_CYCLES) @(posedge eboxClk);
        arstN <= 1'b1;
    end

endmodule
